//--- src/ssm_pkg.sv
package ssm_pkg;

    localparam int DW   = 16;
    localparam int FRAC = 8;

    // Array dimensions of one recurrent step.
    localparam int H = 4;
    localparam int P = 4;
    localparam int N = 4;

    localparam int H_TILE     = 2;
    localparam int P_TILE     = 2;
    localparam int NUM_TILE_H = H / H_TILE;
    localparam int NUM_TILE_P = P / P_TILE;
    localparam int LANES      = H_TILE * P_TILE;

    typedef logic signed [DW-1:0] fx_t;          // Signed Q8.8.
    typedef logic [H*DW-1:0]      head_vec_t;    // dt, dA, D.
    typedef logic [N*DW-1:0]      state_vec_t;   // B, C.
    typedef logic [H*P*DW-1:0]    xy_vec_t;      // Index h*P+p.
    typedef logic [H*P*N*DW-1:0]  hstate_t;      // Index (h*P+p)*N+n.
    typedef logic [3:0]           tile_idx_t;
    typedef logic [$clog2(N)-1:0] n_idx_t;

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_ACC,
        LANE_FINISH
    } lane_state_e;

    typedef enum logic [1:0] {
        PACK_IDLE,
        PACK_RUN,
        PACK_WRITE,
        PACK_DONE
    } pack_state_e;

    // Full product shifted back to Q8.8 and truncated to 16 bits.
    function automatic fx_t fx_mul(fx_t a, fx_t b);
        logic signed [2*DW-1:0] prod;
        prod = a * b;
        return prod[FRAC +: DW];
    endfunction

endpackage

//--- src/ssm_lane.sv
`timescale 1ns/1ps

module ssm_lane
    import ssm_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  fx_t        dt,
    input  fx_t        dA,
    input  fx_t        D,
    input  fx_t        x,
    input  fx_t        b_n,
    input  fx_t        c_n,
    input  state_vec_t h_prev,
    output state_vec_t h_new,
    output fx_t        y,
    output logic       done
);

    lane_state_e state;
    n_idx_t      n_cnt;

    fx_t        dtx;     // dt*x, fixed for the whole step.
    fx_t        acc;
    fx_t        h_cur;
    fx_t        h_upd;
    state_vec_t h_q;

    assign h_cur = h_prev[int'(n_cnt)*DW +: DW];

    // Decay of the old state plus the input injected through B[n].
    assign h_upd = fx_mul(dA, h_cur) + fx_mul(dtx, b_n);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= LANE_IDLE;
            n_cnt <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (start) begin
                        n_cnt <= '0;
                        state <= LANE_ACC;
                    end
                end
                LANE_ACC: begin
                    n_cnt <= n_cnt + 1'b1;
                    if (n_cnt == n_idx_t'(N - 1)) begin
                        state <= LANE_FINISH;
                    end
                end
                LANE_FINISH: begin
                    state <= LANE_IDLE;
                end
                default: begin
                    state <= LANE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LANE_IDLE && start) begin
            dtx <= fx_mul(dt, x);
            acc <= fx_mul(D, x);   // Skip term seeds the sum.
        end else if (state == LANE_ACC) begin
            h_q[int'(n_cnt)*DW +: DW] <= h_upd;
            acc <= acc + fx_mul(c_n, h_upd);
        end
    end

    // The accumulator is final once the last ACC cycle has been taken.
    assign y     = acc;
    assign h_new = h_q;
    assign done  = (state == LANE_FINISH);

endmodule

//--- src/ssm_tile.sv
`timescale 1ns/1ps

module ssm_tile
    import ssm_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [H_TILE*DW-1:0]   dt,
    input  logic [H_TILE*DW-1:0]   dA,
    input  logic [H_TILE*DW-1:0]   D,
    input  logic [LANES*DW-1:0]    x,
    input  state_vec_t             B,
    input  state_vec_t             C,
    input  logic [LANES*N*DW-1:0]  h_prev,
    output logic [LANES*DW-1:0]    y,
    output logic [LANES*N*DW-1:0]  h_new,
    output logic                   done
);

    n_idx_t           n_cnt;
    logic             busy;
    fx_t              b_n;
    fx_t              c_n;
    logic [LANES-1:0] lane_done;

    // Shared n counter, in step with the counters inside the lanes.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            n_cnt <= '0;
            busy  <= 1'b0;
        end else if (start) begin
            n_cnt <= '0;
            busy  <= 1'b1;
        end else if (busy) begin
            n_cnt <= n_cnt + 1'b1;
            if (n_cnt == n_idx_t'(N - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    assign b_n = B[int'(n_cnt)*DW +: DW];
    assign c_n = C[int'(n_cnt)*DW +: DW];

    // Lane i works on head i/P_TILE of the tile.
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        ssm_lane lane_inst (
            .clk    (clk),
            .rst    (rst),
            .start  (start),
            .dt     (dt[(i / P_TILE)*DW +: DW]),
            .dA     (dA[(i / P_TILE)*DW +: DW]),
            .D      (D[(i / P_TILE)*DW +: DW]),
            .x      (x[i*DW +: DW]),
            .b_n    (b_n),
            .c_n    (c_n),
            .h_prev (h_prev[i*N*DW +: N*DW]),
            .h_new  (h_new[i*N*DW +: N*DW]),
            .y      (y[i*DW +: DW]),
            .done   (lane_done[i])
        );
    end

    assign done = lane_done[0];   // All lanes run in lockstep.

endmodule

//--- src/packing.sv
`timescale 1ns/1ps

module packing
    import ssm_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  head_vec_t dt,
    input  head_vec_t dA,
    input  head_vec_t D,
    input  state_vec_t B,
    input  state_vec_t C,
    input  xy_vec_t   x,
    input  hstate_t   h_prev,
    output xy_vec_t   y,
    output hstate_t   h_new,
    output logic      commit,
    output logic      done
);

    pack_state_e state;
    tile_idx_t   h_idx;
    tile_idx_t   p_idx;
    logic        tile_start;
    logic        tile_done;

    logic [H_TILE*DW-1:0]  tile_dt;
    logic [H_TILE*DW-1:0]  tile_dA;
    logic [H_TILE*DW-1:0]  tile_D;
    logic [LANES*DW-1:0]   tile_x;
    logic [LANES*N*DW-1:0] tile_h_prev;
    logic [LANES*DW-1:0]   tile_y;
    logic [LANES*N*DW-1:0] tile_h_new;

    // Position in the full (h,p) array of lane 'lane' of the current tile.
    function automatic int elem_of(tile_idx_t hi, tile_idx_t pi, int lane);
        int h_abs;
        int p_abs;
        h_abs = int'(hi) * H_TILE + lane / P_TILE;
        p_abs = int'(pi) * P_TILE + lane % P_TILE;
        return h_abs * P + p_abs;
    endfunction

    always_comb begin
        for (int i = 0; i < H_TILE; i++) begin
            tile_dt[i*DW +: DW] = dt[(int'(h_idx)*H_TILE + i)*DW +: DW];
            tile_dA[i*DW +: DW] = dA[(int'(h_idx)*H_TILE + i)*DW +: DW];
            tile_D[i*DW +: DW]  = D[(int'(h_idx)*H_TILE + i)*DW +: DW];
        end
        for (int i = 0; i < LANES; i++) begin
            tile_x[i*DW +: DW] = x[elem_of(h_idx, p_idx, i)*DW +: DW];
            for (int n = 0; n < N; n++) begin
                tile_h_prev[(i*N + n)*DW +: DW] =
                    h_prev[(elem_of(h_idx, p_idx, i)*N + n)*DW +: DW];
            end
        end
    end

    ssm_tile tile_inst (
        .clk    (clk),
        .rst    (rst),
        .start  (tile_start),
        .dt     (tile_dt),
        .dA     (tile_dA),
        .D      (tile_D),
        .x      (tile_x),
        .B      (B),
        .C      (C),
        .h_prev (tile_h_prev),
        .y      (tile_y),
        .h_new  (tile_h_new),
        .done   (tile_done)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= PACK_IDLE;
            h_idx      <= '0;
            p_idx      <= '0;
            tile_start <= 1'b0;
            commit     <= 1'b0;
            done       <= 1'b0;
            y          <= '0;
        end else begin
            tile_start <= 1'b0;
            commit     <= 1'b0;
            done       <= 1'b0;
            case (state)
                PACK_IDLE: begin
                    if (start) begin
                        h_idx      <= '0;
                        p_idx      <= '0;
                        tile_start <= 1'b1;
                        state      <= PACK_RUN;
                    end
                end
                PACK_RUN: begin
                    if (tile_done) begin
                        state <= PACK_WRITE;
                    end
                end
                PACK_WRITE: begin
                    for (int i = 0; i < LANES; i++) begin
                        y[elem_of(h_idx, p_idx, i)*DW +: DW] <= tile_y[i*DW +: DW];
                    end
                    // p steps inside h.
                    if (p_idx == tile_idx_t'(NUM_TILE_P - 1)) begin
                        p_idx <= '0;
                        if (h_idx == tile_idx_t'(NUM_TILE_H - 1)) begin
                            h_idx <= '0;
                            state <= PACK_DONE;
                        end else begin
                            h_idx      <= h_idx + 1'b1;
                            tile_start <= 1'b1;
                            state      <= PACK_RUN;
                        end
                    end else begin
                        p_idx      <= p_idx + 1'b1;
                        tile_start <= 1'b1;
                        state      <= PACK_RUN;
                    end
                end
                PACK_DONE: begin
                    commit <= 1'b1;
                    done   <= 1'b1;
                    state  <= PACK_IDLE;
                end
                default: begin
                    state <= PACK_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PACK_WRITE) begin
            for (int i = 0; i < LANES; i++) begin
                for (int n = 0; n < N; n++) begin
                    h_new[(elem_of(h_idx, p_idx, i)*N + n)*DW +: DW] <=
                        tile_h_new[(i*N + n)*DW +: DW];
                end
            end
        end
    end

endmodule

//--- src/state_store.sv
`timescale 1ns/1ps

module state_store
    import ssm_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    clear,
    input  logic    commit,
    input  hstate_t h_new,
    output hstate_t h_state
);

    // Recurrent state carried from one step to the next.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_state <= '0;
        end else if (clear) begin
            h_state <= '0;      // A clear in the commit cycle drops the new state.
        end else if (commit) begin
            h_state <= h_new;
        end
    end

endmodule

//--- src/ssm_top.sv
`timescale 1ns/1ps

module ssm_top
    import ssm_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       clear,
    input  head_vec_t  dt,
    input  head_vec_t  dA,
    input  head_vec_t  D,
    input  state_vec_t B,
    input  state_vec_t C,
    input  xy_vec_t    x,
    output xy_vec_t    y,
    output hstate_t    h_state,
    output logic       done
);

    hstate_t h_new;
    logic    commit;

    // The stored state feeds the controller as h_prev.
    packing packing_inst (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .dt     (dt),
        .dA     (dA),
        .D      (D),
        .B      (B),
        .C      (C),
        .x      (x),
        .h_prev (h_state),
        .y      (y),
        .h_new  (h_new),
        .commit (commit),
        .done   (done)
    );

    state_store state_store_inst (
        .clk     (clk),
        .rst     (rst),
        .clear   (clear),
        .commit  (commit),
        .h_new   (h_new),
        .h_state (h_state)
    );

endmodule

//--- testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1. The new bit enters at bit 0.
function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// Signed Q8.8 product. The full product loses its low 8 bits and keeps 16.
function automatic fx_t fx_product(fx_t a, fx_t b);
    logic signed [31:0] full;
    full = 32'(a) * 32'(b);
    return full[23:8];
endfunction

// New state value, dA*h_prev + (dt*x)*B[n], wrapping at 16 bits.
function automatic fx_t state_update(fx_t da, fx_t h_prev, fx_t dtx, fx_t b);
    return fx_product(da, h_prev) + fx_product(dtx, b);
endfunction

// One tile costs N+3 cycles. The start pulse and the DONE state cost one more cycle each.
function automatic int step_latency();
    return (H / H_TILE) * (P / P_TILE) * (N + 3) + 2;
endfunction

// One (h,p) element of a step: N state updates and the output sum.
task automatic model_element(input fx_t dt, input fx_t da, input fx_t d, input fx_t x,
                             input fx_t b [N], input fx_t c [N], input fx_t h_prev [N],
                             output fx_t h_next [N], output fx_t y);
    fx_t dtx;
    dtx = fx_product(dt, x);
    y   = fx_product(d, x);              // Skip term.
    for (int n = 0; n < N; n++) begin
        h_next[n] = state_update(da, h_prev[n], dtx, b[n]);
        y         = y + fx_product(c[n], h_next[n]);
    end
endtask

`endif

//--- testbench/tb_ssm_top.sv
`timescale 1ns/1ps

module tb_ssm_top
    import ssm_pkg::*;
();

    localparam int NUM_TESTS = 7;

    // Each test holds a name, a clear flag, a step count, an amplitude shift and a busy start flag.
    string test_name   [NUM_TESTS] = '{"first_after_clear", "recurrence", "clear_restart",
                                       "recurrence_wide", "busy_start", "wrap_full_range",
                                       "busy_after_clear"};
    bit    do_clear    [NUM_TESTS] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
    int    step_cnt    [NUM_TESTS] = '{1, 3, 1, 2, 1, 2, 1};
    int    amp_shift   [NUM_TESTS] = '{6, 6, 5, 4, 6, 0, 7};
    bit    extra_start [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};

    logic       clk = 1'b0;
    logic       rst;
    logic       start;
    logic       clear;
    head_vec_t  dt_bus;
    head_vec_t  da_bus;
    head_vec_t  d_bus;
    state_vec_t b_bus;
    state_vec_t c_bus;
    xy_vec_t    x_bus;
    xy_vec_t    y_bus;
    hstate_t    h_bus;
    logic       done;

    fx_t dt_v    [H];
    fx_t da_v    [H];
    fx_t d_v     [H];
    fx_t b_v     [N];
    fx_t c_v     [N];
    fx_t x_v     [H*P];
    fx_t m_y     [H*P];
    fx_t m_state [H*P*N];      // Model copy of the recurrent state.
    fx_t m_next  [H*P*N];

    logic [31:0] lfsr_state    = 32'hedc5bbe1;
    int          cycle_cnt     = 0;
    int          timeout_limit = 200;
    int          mismatch_cnt  = 0;
    int          fail_cnt      = 0;
    int          check_cnt     = 0;

    `include "tb_model.svh"

    always #2 clk = ~clk;

    ssm_top ssm_top_inst (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .clear   (clear),
        .dt      (dt_bus),
        .dA      (da_bus),
        .D       (d_bus),
        .B       (b_bus),
        .C       (c_bus),
        .x       (x_bus),
        .y       (y_bus),
        .h_state (h_bus),
        .done    (done)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", timeout_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Sixteen fresh LFSR bits, scaled down by the amplitude shift.
    function automatic fx_t rand_fx(int shift);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[14:0], lfsr_state[0]};
        end
        return fx_t'($signed(bits) >>> shift);
    endfunction

    task automatic check_value(string test, string what, fx_t expected, fx_t actual);
        check_cnt++;
        if (actual !== expected) begin
            mismatch_cnt++;
            $display("Mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    task automatic check_state(string test);
        for (int e = 0; e < H*P; e++) begin
            for (int n = 0; n < N; n++) begin
                check_value(test, $sformatf("h_state h%0d p%0d n%0d", e / P, e % P, n),
                            m_state[e*N + n], h_bus[(e*N + n)*DW +: DW]);
            end
        end
    endtask

    task automatic run_model();
        fx_t hp [N];
        fx_t hn [N];
        fx_t ye;
        for (int e = 0; e < H*P; e++) begin
            for (int n = 0; n < N; n++) begin
                hp[n] = m_state[e*N + n];
            end
            model_element(dt_v[e / P], da_v[e / P], d_v[e / P], x_v[e], b_v, c_v, hp, hn, ye);
            for (int n = 0; n < N; n++) begin
                m_next[e*N + n] = hn[n];
            end
            m_y[e] = ye;
        end
    endtask

    task automatic pulse_clear(string test);
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < H*P*N; i++) begin
            m_state[i] = '0;
        end
        check_state($sformatf("%s clear", test));
    endtask

    task automatic run_step(int t, int s);
        head_vec_t  dt_p;
        head_vec_t  da_p;
        head_vec_t  d_p;
        state_vec_t b_p;
        state_vec_t c_p;
        xy_vec_t    x_p;
        string      tag;
        int         k;
        bit         seen;
        tag = $sformatf("%s step %0d", test_name[t], s);
        for (int h = 0; h < H; h++) begin
            dt_v[h] = rand_fx(amp_shift[t]);
            da_v[h] = rand_fx(amp_shift[t]);
            d_v[h]  = rand_fx(amp_shift[t]);
            dt_p[h*DW +: DW] = dt_v[h];
            da_p[h*DW +: DW] = da_v[h];
            d_p[h*DW +: DW]  = d_v[h];
        end
        for (int n = 0; n < N; n++) begin
            b_v[n] = rand_fx(amp_shift[t]);
            c_v[n] = rand_fx(amp_shift[t]);
            b_p[n*DW +: DW] = b_v[n];
            c_p[n*DW +: DW] = c_v[n];
        end
        for (int e = 0; e < H*P; e++) begin
            x_v[e] = rand_fx(amp_shift[t]);
            x_p[e*DW +: DW] = x_v[e];
        end
        run_model();

        @(posedge clk);
        dt_bus <= dt_p;
        da_bus <= da_p;
        d_bus  <= d_p;
        b_bus  <= b_p;
        c_bus  <= c_p;
        x_bus  <= x_p;
        start  <= 1'b1;
        k      = 0;
        seen   = 1'b0;
        while (!seen && k < 2 * step_latency()) begin
            @(posedge clk);
            k++;
            start <= (extra_start[t] && k == 12);   // The second start falls mid-step.
            @(negedge clk);
            seen = done;
        end
        if (!seen) begin
            fail_cnt++;
            $display("Error: %s, done did not arrive within %0d cycles of start", tag, k);
        end else if (k != step_latency()) begin
            mismatch_cnt++;
            $display("Mismatch %s latency: expected %0d, actual %0d", tag, step_latency(), k);
        end
        for (int e = 0; e < H*P; e++) begin
            check_value(tag, $sformatf("y h%0d p%0d", e / P, e % P), m_y[e], y_bus[e*DW +: DW]);
        end

        // The committed state shows up one cycle after done.
        m_state = m_next;
        @(negedge clk);
        if (done) begin
            fail_cnt++;
            $display("Error: %s, done stayed high for more than one cycle", tag);
        end
        check_state(tag);
        if (extra_start[t]) begin
            for (int i = 0; i < step_latency() + 4; i++) begin
                @(negedge clk);
                if (done) begin
                    fail_cnt++;
                    $display("Error: %s, a second done followed the start given while busy", tag);
                end
            end
        end
    endtask

    initial begin
        int total_steps;
        total_steps = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_steps += step_cnt[t];
        end
        timeout_limit = total_steps * 40 + 200;
        rst    = 1'b1;
        start  = 1'b0;
        clear  = 1'b0;
        dt_bus = '0;
        da_bus = '0;
        d_bus  = '0;
        b_bus  = '0;
        c_bus  = '0;
        x_bus  = '0;
        for (int i = 0; i < H*P*N; i++) begin
            m_state[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            if (do_clear[t]) begin
                pulse_clear(test_name[t]);
            end
            for (int s = 0; s < step_cnt[t]; s++) begin
                run_step(t, s);
            end
        end

        repeat (4) @(posedge clk);
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_cnt, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+testbench
src/ssm_pkg.sv
src/ssm_lane.sv
src/ssm_tile.sv
src/packing.sv
src/state_store.sv
src/ssm_top.sv
testbench/tb_ssm_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_ssm_top -o tb_ssm_top \
    || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/tb_ssm_top)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -q "ALL TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
